/* mem_cache_pkg.sv */
`default_nettype none

package mem_cache_pkg;

  localparam int LINE_WORDS     = 16;  // words per cache line
  localparam int BEATS_PER_LINE = 2;   // ddr2 beats per cache line

  typedef logic [32:0] word_addr_t;  // host word address
  typedef logic [15:0] word_t;       // host data word

  // a line address is the word address with the word index dropped
  typedef logic [$bits(word_addr_t)-$clog2(LINE_WORDS)-1:0] line_addr_t;
  typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;

  typedef logic [30:0] ddr_addr_t;  // ddr2 beat address
  typedef logic [LINE_WORDS*$bits(word_t)-1:0] line_data_t;
  typedef logic [$bits(line_data_t)/BEATS_PER_LINE-1:0] ddr_beat_t;  // word 0 in low bits

  // classified host request
  typedef struct packed {
    line_addr_t line;
    word_idx_t  idx;
    logic       hit_cur;   // line is current and loaded
    logic       hit_next;  // line is the next slot, loaded or in flight
  } lookup_t;

  // claim of a slot for an incoming line
  typedef struct packed {
    line_addr_t line;
    logic       to_next;  // 1 fills the next slot, 0 the current one
  } fill_cmd_t;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_REQ_A,
    FETCH_REQ_B,
    FETCH_WAIT_FILL,
    FETCH_SERVE
  } fetch_state_e;

endpackage

`default_nettype wire

/* rd_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module rd_lookup (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rd_strb_i,
  input  mem_cache_pkg::word_addr_t rd_addr_i,
  input  mem_cache_pkg::line_addr_t cur_tag_i,
  input  mem_cache_pkg::line_addr_t next_tag_i,
  input  logic                      cur_valid_i,
  input  logic                      next_tag_set_i,
  output mem_cache_pkg::lookup_t    lookup_o,
  output logic                      lookup_vld_o
);
  import mem_cache_pkg::*;

  word_addr_t req_addr;
  logic       req_vld;
  line_addr_t req_line;
  word_idx_t  req_idx;
  logic       hit_cur;
  logic       hit_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= rd_strb_i;  // one cycle pulse follows the strobe
    end
  end

  always_ff @(posedge clk) begin
    if (rd_strb_i) begin
      req_addr <= rd_addr_i;
    end
  end

  assign req_line = req_addr[$bits(word_addr_t)-1:$bits(word_idx_t)];
  assign req_idx  = req_addr[$bits(word_idx_t)-1:0];

  // tags are compared after the register, so a slot change made
  // while the strobe was in flight is already visible
  assign hit_cur  = cur_valid_i && (cur_tag_i == req_line);

  // a set tag counts even while its fill is pending; fetch_ctrl waits for it
  assign hit_next = !hit_cur && next_tag_set_i && (next_tag_i == req_line);

  always_comb begin
    lookup_o          = '0;
    lookup_o.line     = req_line;
    lookup_o.idx      = req_idx;
    lookup_o.hit_cur  = hit_cur;
    lookup_o.hit_next = hit_next;
  end

  assign lookup_vld_o = req_vld;

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_cache_pkg::lookup_t    lookup_i,
  input  logic                      lookup_vld_i,
  input  logic                      fill_done_i,
  input  logic                      next_valid_i,
  input  logic                      ddr_af_full_i,
  output mem_cache_pkg::ddr_addr_t  ddr_addr_o,
  output logic                      ddr_strb_o,
  output mem_cache_pkg::fill_cmd_t  fill_cmd_o,
  output logic                      fill_start_o,
  output logic                      advance_o,
  output logic                      serve_o,
  output mem_cache_pkg::word_idx_t  serve_idx_o
);
  import mem_cache_pkg::*;

  fetch_state_e state;
  lookup_t      pend;       // request held until it is served
  logic         pend_vld;
  lookup_t      req;
  logic         req_vld;
  line_addr_t   req_line;   // line for the next ddr2 request
  logic         miss_mode;  // 1 while a double fetch is being served
  logic [1:0]   fill_cnt;   // fills claimed but not yet complete
  logic         serve_hit;
  logic         req_done;
  logic         issue;

  // a fresh lookup is used directly so a hit costs no extra cycle
  assign req     = lookup_vld_i ? lookup_i : pend;
  assign req_vld = lookup_vld_i | pend_vld;

  // current line hits are served in any state except the serve itself
  assign serve_hit = req_vld && req.hit_cur && (state != FETCH_SERVE);
  assign req_done  = serve_hit || (state == FETCH_SERVE);

  // the strobe is gated by the live almost-full flag so it never goes out while full
  assign issue      = ((state == FETCH_REQ_A) || (state == FETCH_REQ_B)) && !ddr_af_full_i;
  assign ddr_strb_o = issue;
  assign ddr_addr_o = ddr_addr_t'(req_line) << 1;  // first beat of the line

  always_ff @(posedge clk) begin
    if (lookup_vld_i) begin
      pend <= lookup_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= FETCH_IDLE;
      pend_vld     <= 1'b0;
      miss_mode    <= 1'b0;
      fill_cnt     <= 2'd0;
      serve_o      <= 1'b0;
      advance_o    <= 1'b0;
      fill_start_o <= 1'b0;
    end else begin
      serve_o      <= 1'b0;
      advance_o    <= 1'b0;
      fill_start_o <= 1'b0;
      pend_vld     <= req_vld && !req_done;

      case ({fill_start_o, fill_done_i})
        2'b10:   fill_cnt <= fill_cnt + 2'd1;
        2'b01:   fill_cnt <= fill_cnt - 2'd1;
        default: fill_cnt <= fill_cnt;
      endcase

      if (serve_hit) begin
        serve_o     <= 1'b1;
        serve_idx_o <= req.idx;
      end

      case (state)
        FETCH_IDLE: begin
          if (req_vld && req.hit_next) begin
            // slots are renamed only once no fill is in flight
            if (next_valid_i && (fill_cnt == 2'd0)) begin
              advance_o <= 1'b1;
              miss_mode <= 1'b0;
              state     <= FETCH_SERVE;
            end
          end else if (req_vld && !req.hit_cur && (fill_cnt == 2'd0)) begin
            fill_start_o       <= 1'b1;  // requested line goes to the current slot
            fill_cmd_o.line    <= req.line;
            fill_cmd_o.to_next <= 1'b0;
            req_line           <= req.line;
            miss_mode          <= 1'b1;
            state              <= FETCH_REQ_A;
          end
        end
        FETCH_REQ_A: begin
          if (issue) begin
            fill_start_o       <= 1'b1;  // successor goes to the next slot
            fill_cmd_o.line    <= req_line + 1'b1;
            fill_cmd_o.to_next <= 1'b1;
            req_line           <= req_line + 1'b1;
            state              <= FETCH_REQ_B;
          end
        end
        FETCH_REQ_B: begin
          if (issue) begin
            state <= miss_mode ? FETCH_WAIT_FILL : FETCH_IDLE;
          end
        end
        FETCH_WAIT_FILL: begin
          // fills complete in order, the first one done is the requested line
          if (fill_done_i || (fill_cnt < 2'd2)) begin
            state <= FETCH_SERVE;
          end
        end
        FETCH_SERVE: begin
          serve_o     <= 1'b1;
          serve_idx_o <= pend.idx;
          if (miss_mode) begin
            state <= FETCH_IDLE;
          end else begin
            fill_start_o       <= 1'b1;  // prefetch after the advance
            fill_cmd_o.line    <= pend.line + 1'b1;
            fill_cmd_o.to_next <= 1'b1;
            req_line           <= pend.line + 1'b1;
            state              <= FETCH_REQ_B;
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* line_store.sv */
`timescale 1ns/100ps
`default_nettype none

module line_store (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_cache_pkg::fill_cmd_t  fill_cmd_i,
  input  logic                      fill_start_i,
  input  logic                      advance_i,
  input  logic                      serve_i,
  input  mem_cache_pkg::word_idx_t  serve_idx_i,
  input  mem_cache_pkg::ddr_beat_t  ddr_data_i,
  input  logic                      ddr_dvalid_i,
  output mem_cache_pkg::line_addr_t cur_tag_o,
  output mem_cache_pkg::line_addr_t next_tag_o,
  output logic                      cur_valid_o,
  output logic                      next_valid_o,
  output logic                      next_tag_set_o,
  output logic                      fill_done_o,
  output mem_cache_pkg::word_t      rd_data_o,
  output logic                      rd_ack_o
);
  import mem_cache_pkg::*;

  line_data_t slot_data [2];  // two physical slots
  line_addr_t slot_tag [2];
  logic [1:0] slot_valid;
  logic [1:0] slot_tag_set;
  logic       cur_sel;        // physical slot holding the current line

  // fill FIFO keeps the physical slot of each pending fill
  logic [1:0] fifo_slot;
  logic       fifo_wr_ptr;
  logic       fifo_rd_ptr;

  logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
  logic       fill_slot;
  logic       head_slot;
  logic       last_beat;
  word_t [LINE_WORDS-1:0] cur_words;

  assign fill_slot = fill_cmd_i.to_next ? ~cur_sel : cur_sel;
  assign head_slot = fifo_slot[fifo_rd_ptr];
  assign last_beat = (beat_cnt == BEATS_PER_LINE - 1);

  assign cur_tag_o      = slot_tag[cur_sel];
  assign next_tag_o     = slot_tag[~cur_sel];
  assign cur_valid_o    = slot_valid[cur_sel];
  assign next_valid_o   = slot_valid[~cur_sel];
  assign next_tag_set_o = slot_tag_set[~cur_sel];

  // beats land in the slot at the FIFO head; since entries hold the physical
  // slot, a fill in flight across an advance still reaches the renamed slot
  always_ff @(posedge clk) begin
    if (ddr_dvalid_i) begin
      slot_data[head_slot][beat_cnt*$bits(ddr_beat_t) +: $bits(ddr_beat_t)] <= ddr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start_i) begin
      slot_tag[fill_slot]    <= fill_cmd_i.line;
      fifo_slot[fifo_wr_ptr] <= fill_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid   <= 2'b00;
      slot_tag_set <= 2'b00;
      cur_sel      <= 1'b0;
      fifo_wr_ptr  <= 1'b0;
      fifo_rd_ptr  <= 1'b0;
      beat_cnt     <= '0;
      fill_done_o  <= 1'b0;
    end else begin
      fill_done_o <= 1'b0;
      if (ddr_dvalid_i) begin
        if (last_beat) begin
          beat_cnt               <= '0;
          fifo_rd_ptr            <= ~fifo_rd_ptr;  // pop
          slot_valid[head_slot]  <= 1'b1;
          fill_done_o            <= 1'b1;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
      if (advance_i) begin
        cur_sel               <= ~cur_sel;
        slot_valid[cur_sel]   <= 1'b0;  // old current slot becomes the empty next slot
        slot_tag_set[cur_sel] <= 1'b0;
      end
      if (fill_start_i) begin
        slot_valid[fill_slot]   <= 1'b0;
        slot_tag_set[fill_slot] <= 1'b1;
        fifo_wr_ptr             <= ~fifo_wr_ptr;  // push
      end
    end
  end

  assign cur_words = slot_data[cur_sel];

  always_ff @(posedge clk) begin
    if (serve_i) begin
      rd_data_o <= cur_words[serve_idx_i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ack_o <= 1'b0;
    end else begin
      rd_ack_o <= serve_i;  // ack in the same cycle as the data
    end
  end

endmodule

`default_nettype wire

/* mem_rd_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_rd_cache (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rd_strb_i,
  input  mem_cache_pkg::word_addr_t rd_addr_i,
  output mem_cache_pkg::word_t      rd_data_o,
  output logic                      rd_ack_o,
  output mem_cache_pkg::ddr_addr_t  ddr_addr_o,
  output logic                      ddr_strb_o,
  input  mem_cache_pkg::ddr_beat_t  ddr_data_i,
  input  logic                      ddr_dvalid_i,
  input  logic                      ddr_af_full_i
);
  import mem_cache_pkg::*;

  lookup_t    lookup;
  logic       lookup_vld;
  line_addr_t cur_tag;
  line_addr_t next_tag;
  logic       cur_valid;
  logic       next_valid;
  logic       next_tag_set;
  fill_cmd_t  fill_cmd;
  logic       fill_start;
  logic       fill_done;
  logic       advance;
  logic       serve;
  word_idx_t  serve_idx;

  rd_lookup u_rd_lookup (
    .clk            (clk),
    .reset          (reset),
    .rd_strb_i      (rd_strb_i),
    .rd_addr_i      (rd_addr_i),
    .cur_tag_i      (cur_tag),
    .next_tag_i     (next_tag),
    .cur_valid_i    (cur_valid),
    .next_tag_set_i (next_tag_set),
    .lookup_o       (lookup),
    .lookup_vld_o   (lookup_vld)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .reset         (reset),
    .lookup_i      (lookup),
    .lookup_vld_i  (lookup_vld),
    .fill_done_i   (fill_done),
    .next_valid_i  (next_valid),
    .ddr_af_full_i (ddr_af_full_i),
    .ddr_addr_o    (ddr_addr_o),
    .ddr_strb_o    (ddr_strb_o),
    .fill_cmd_o    (fill_cmd),
    .fill_start_o  (fill_start),
    .advance_o     (advance),
    .serve_o       (serve),
    .serve_idx_o   (serve_idx)
  );

  line_store u_line_store (
    .clk            (clk),
    .reset          (reset),
    .fill_cmd_i     (fill_cmd),
    .fill_start_i   (fill_start),
    .advance_i      (advance),
    .serve_i        (serve),
    .serve_idx_i    (serve_idx),
    .ddr_data_i     (ddr_data_i),
    .ddr_dvalid_i   (ddr_dvalid_i),
    .cur_tag_o      (cur_tag),
    .next_tag_o     (next_tag),
    .cur_valid_o    (cur_valid),
    .next_valid_o   (next_valid),
    .next_tag_set_o (next_tag_set),
    .fill_done_o    (fill_done),
    .rd_data_o      (rd_data_o),
    .rd_ack_o       (rd_ack_o)
  );

endmodule

`default_nettype wire

/* tb_ddr_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ddr_model (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     bp_en_i,
  input  mem_cache_pkg::ddr_addr_t ddr_addr_i,
  input  logic                     ddr_strb_i,
  output mem_cache_pkg::ddr_beat_t ddr_data_o,
  output logic                     ddr_dvalid_o,
  output logic                     ddr_af_full_o
);
  import mem_cache_pkg::*;

  localparam int RETURN_DELAY = 6;  // cycles from request to first beat

  ddr_addr_t   req_q [$];
  int unsigned due_q [$];
  int unsigned cycle;
  logic        beat_sel;
  logic [31:0] lfsr;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // word w of beat b holds the low bits of b*8+w, scrambled
  function automatic ddr_beat_t beat_pattern(input ddr_addr_t b);
    logic [33:0] word_addr;
    ddr_beat_t   beat;
    for (int w = 0; w < 8; w++) begin
      word_addr          = {3'b000, b} * 8 + w;
      beat[w*16 +: 16] = word_addr[15:0] ^ 16'h5a3c;
    end
    return beat;
  endfunction

  initial begin
    ddr_data_o    = '0;
    ddr_dvalid_o  = 1'b0;
    ddr_af_full_o = 1'b0;
    cycle         = 0;
    beat_sel      = 1'b0;
    lfsr          = 32'hb54be49c;
  end

  always @(posedge clk) begin
    cycle++;
    if (reset) begin
      req_q.delete();
      due_q.delete();
    end else if (ddr_strb_i) begin
      req_q.push_back(ddr_addr_i);
      due_q.push_back(cycle + RETURN_DELAY);
    end
  end

  // beats and almost-full change on the falling edge
  always @(negedge clk) begin
    ddr_dvalid_o = 1'b0;
    if (reset) begin
      beat_sel = 1'b0;
    end else if (req_q.size() != 0 && cycle >= due_q[0]) begin
      ddr_dvalid_o = 1'b1;
      ddr_data_o   = beat_pattern(req_q[0] + ddr_addr_t'(beat_sel));
      if (beat_sel) begin
        void'(req_q.pop_front());
        void'(due_q.pop_front());
      end
      beat_sel = ~beat_sel;
    end
    lfsr          = lfsr_step(lfsr);
    ddr_af_full_o = lfsr[0];
    lfsr          = lfsr_step(lfsr);
    ddr_af_full_o = bp_en_i && ddr_af_full_o && lfsr[0];  // about one cycle in four
  end

endmodule

`default_nettype wire

/* mem_rd_cache_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_rd_cache_checker (
  input logic clk,
  input logic reset,
  input logic rd_strb_i,
  input logic rd_ack_o,
  input logic ddr_strb_o,
  input logic ddr_af_full_i
);

  logic rd_pending;  // a host read is waiting for its ack

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else if (rd_strb_i) begin
      rd_pending <= 1'b1;
    end else if (rd_ack_o) begin
      rd_pending <= 1'b0;
    end
  end

  a_no_req_while_full: assert property (@(posedge clk) disable iff (reset)
    !(ddr_strb_o && ddr_af_full_i))
    else $error("ddr2 request issued while almost full");

  a_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    rd_ack_o |=> !rd_ack_o)
    else $error("rd_ack_o held longer than one cycle");

  a_ack_after_strb: assert property (@(posedge clk) disable iff (reset)
    rd_ack_o |-> rd_pending)
    else $error("rd_ack_o without a preceding rd_strb_i");

endmodule

bind mem_rd_cache mem_rd_cache_checker u_checker (.*);

`default_nettype wire

/* tb_mem_rd_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_rd_cache;
  import mem_cache_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int TABLE_N    = 16;
  localparam int RAND_N     = 24;

  typedef struct packed {
    word_addr_t addr;
    logic       hit;   // expected hit in the current line
    logic [1:0] reqs;  // ddr2 requests expected up to the ack
  } read_vec_t;

  read_vec_t vec_table [TABLE_N] = '{
    '{33'h0_0001_2345, 1'b0, 2'd2},  // cold miss on line 0x1234
    '{33'h0_0001_2345, 1'b1, 2'd0},
    '{33'h0_0001_234f, 1'b1, 2'd0},
    '{33'h0_0001_2350, 1'b0, 2'd1},  // cross into the prefetched line
    '{33'h0_0001_2358, 1'b1, 2'd0},
    '{33'h0_0001_235f, 1'b1, 2'd0},
    '{33'h0_0001_2360, 1'b0, 2'd1},
    '{33'h0_0001_2340, 1'b0, 2'd2},  // jump back
    '{33'h0_0001_2347, 1'b1, 2'd0},
    '{33'h1_ffff_fff3, 1'b0, 2'd2},  // top line whose successor wraps to 0
    '{33'h1_ffff_fffa, 1'b1, 2'd0},
    '{33'h0_0000_0001, 1'b0, 2'd1},
    '{33'h0_0000_0010, 1'b0, 2'd1},
    '{33'h0_0000_0002, 1'b0, 2'd2},
    '{33'h0_0000_000e, 1'b1, 2'd0},
    '{33'h0_0000_0008, 1'b1, 2'd0}
  };

  logic       clk = 1'b0;
  logic       reset;
  logic       rd_strb;
  word_addr_t rd_addr;
  word_t      rd_data;
  logic       rd_ack;
  ddr_addr_t  ddr_addr;
  logic       ddr_strb;
  ddr_beat_t  ddr_data;
  logic       ddr_dvalid;
  logic       ddr_af_full;
  logic       bp_en;

  int          errors = 0;
  int unsigned req_cnt = 0;
  ddr_addr_t   exp_q [$];   // ddr2 requests predicted by the two-line model
  line_addr_t  m_cur;
  line_addr_t  m_next;
  logic        m_valid;
  logic [31:0] lfsr = 32'hb54be49c;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mem_rd_cache dut (
    .clk           (clk),
    .reset         (reset),
    .rd_strb_i     (rd_strb),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .rd_ack_o      (rd_ack),
    .ddr_addr_o    (ddr_addr),
    .ddr_strb_o    (ddr_strb),
    .ddr_data_i    (ddr_data),
    .ddr_dvalid_i  (ddr_dvalid),
    .ddr_af_full_i (ddr_af_full)
  );

  tb_ddr_model ddr (
    .clk           (clk),
    .reset         (reset),
    .bp_en_i       (bp_en),
    .ddr_addr_i    (ddr_addr),
    .ddr_strb_i    (ddr_strb),
    .ddr_data_o    (ddr_data),
    .ddr_dvalid_o  (ddr_dvalid),
    .ddr_af_full_o (ddr_af_full)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // word w of beat b carries the scrambled value of b*8+w
  function automatic word_t expected_word(input word_addr_t addr);
    logic [33:0] beat;
    logic [33:0] value;
    beat  = {1'b0, addr} >> 3;
    value = beat * 8 + addr[2:0];
    return value[15:0] ^ 16'h5a3c;
  endfunction

  task automatic random_bits(input int n, output logic [32:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[31:0], lfsr[0]};
    end
  endtask

  // predicts the ddr2 requests of one read from the two-line model
  task automatic predict_requests(input word_addr_t addr);
    line_addr_t line;
    line = addr[32:4];
    if (m_valid && line == m_next) begin
      m_cur  = line;
      m_next = line + 1'b1;
      exp_q.push_back(ddr_addr_t'({m_next, 1'b0}));
    end else if (!m_valid || line != m_cur) begin
      m_cur   = line;
      m_next  = line + 1'b1;
      m_valid = 1'b1;
      exp_q.push_back(ddr_addr_t'({m_cur, 1'b0}));
      exp_q.push_back(ddr_addr_t'({m_next, 1'b0}));
    end
  endtask

  task automatic apply_reset();
    reset   = 1'b1;
    m_valid = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (i == 7) begin
        reset = 1'b0;
      end
      if (rd_ack !== 1'b0 || ddr_strb !== 1'b0) begin
        $display("CHECK FAILED at %0t: rd_ack_o/ddr_strb_o expected 0/0 got %b/%b",
                 $time, rd_ack, ddr_strb);
        errors++;
      end
    end
  endtask

  task automatic host_read(input word_addr_t addr, output int cycles,
                           output int unsigned nreq);
    int unsigned start_cnt;
    predict_requests(addr);
    @(negedge clk);
    rd_strb   = 1'b1;
    rd_addr   = addr;
    start_cnt = req_cnt;
    cycles    = 1;
    @(negedge clk);
    rd_strb = 1'b0;
    while (!rd_ack) begin
      @(negedge clk);
      cycles++;
    end
    nreq = req_cnt - start_cnt;
    if (rd_data !== expected_word(addr)) begin
      $display("CHECK FAILED at %0t: rd_data_o expected %h got %h",
               $time, expected_word(addr), rd_data);
      errors++;
    end
  endtask

  task automatic run_table();
    int          cycles;
    int unsigned nreq;
    for (int i = 0; i < TABLE_N; i++) begin
      host_read(vec_table[i].addr, cycles, nreq);
      if (vec_table[i].hit && cycles != 3) begin
        $display("CHECK FAILED at %0t: rd_ack_o latency expected 3 got %0d",
                 $time, cycles);
        errors++;
      end
      // back-pressure can push a prefetch into a later window
      if (!bp_en && nreq != vec_table[i].reqs) begin
        $display("CHECK FAILED at %0t: ddr_strb_o count expected %0d got %0d",
                 $time, vec_table[i].reqs, nreq);
        errors++;
      end
    end
  endtask

  // every request must match the next predicted beat address
  always @(posedge clk) begin
    if (!reset && ddr_strb) begin
      req_cnt++;
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: DDR2 request to %h was not expected", $time, ddr_addr);
        errors++;
      end else begin
        if (ddr_addr !== exp_q[0]) begin
          $display("CHECK FAILED at %0t: ddr_addr_o expected %h got %h",
                   $time, exp_q[0], ddr_addr);
          errors++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    #((2 * TABLE_N + RAND_N) * 64 * CLK_PERIOD);
    $display("ERROR: watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    word_addr_t  addr;
    logic [32:0] rnd;
    int          cycles;
    int unsigned nreq;
    rd_strb = 1'b0;
    rd_addr = '0;
    bp_en   = 1'b0;
    addr    = '0;
    apply_reset();
    run_table();
    while (exp_q.size() != 0) @(negedge clk);

    bp_en = 1'b1;  // same table again under random almost-full
    apply_reset();
    run_table();

    for (int i = 0; i < RAND_N; i++) begin
      random_bits(1, rnd);
      if (rnd[0]) begin
        random_bits(5, rnd);
        addr = addr + rnd;  // short step that mostly hits or advances
      end else begin
        random_bits(33, rnd);
        addr = rnd;
      end
      host_read(addr, cycles, nreq);
    end
    while (exp_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
mem_cache_pkg.sv
rd_lookup.sv
fetch_ctrl.sv
line_store.sv
mem_rd_cache.sv
tb_ddr_model.sv
mem_rd_cache_checker.sv
tb_mem_rd_cache.sv

/* Bender.yml */
package:
  name: mem_rd_cache

sources:
  - files:
      - mem_cache_pkg.sv
      - rd_lookup.sv
      - fetch_ctrl.sv
      - line_store.sv
      - mem_rd_cache.sv
  - target: simulation
    files:
      - tb_ddr_model.sv
      - mem_rd_cache_checker.sv
      - tb_mem_rd_cache.sv
